//--- hdl/l1_cache_pkg.sv
package l1_cache_pkg;

	// Cache geometry. One word per line, direct mapped.
	localparam int data_width  = 32;
	localparam int addr_width  = 10;	// Word address.
	localparam int index_width = 4;
	localparam int tag_width   = 6;
	localparam int num_lines   = 16;

	// Controller states.
	typedef enum logic [3:0] {
		st_idle,
		st_compare,
		st_read_miss,
		st_read_mem,
		st_read_data,
		st_write_hit,
		st_write_miss,
		st_write_mem,
		st_write_data,
		st_write_back,
		st_write_back_mem
	} cache_state_e;

	typedef struct packed {
		logic                  we;
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic                 valid;
		logic                 dirty;
		logic [tag_width-1:0] tag;
	} tag_entry_t;

	typedef struct packed {
		logic                  we;
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] wdata;
	} dram_req_t;

	// Address split: tag in the upper bits, index in the lower bits.
	function automatic logic [index_width-1:0] addr_index(input logic [addr_width-1:0] addr);
		return addr[index_width-1:0];
	endfunction

	function automatic logic [tag_width-1:0] addr_tag(input logic [addr_width-1:0] addr);
		return addr[addr_width-1 -: tag_width];
	endfunction

	// Rebuilds a word address from a stored tag and its line index.
	function automatic logic [addr_width-1:0] make_addr(input logic [tag_width-1:0] tag,
		input logic [index_width-1:0] index);
		return {tag, index};
	endfunction

endpackage

//--- hdl/l1_tag_store.sv
`timescale 1ns/1ps

module l1_tag_store
	import l1_cache_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,

	// Lookup side.
	input  logic [index_width-1:0] index,
	input  logic [tag_width-1:0]   tag,
	output tag_entry_t             lookup,
	output logic                   hit,

	// Update side.
	input  logic                   tag_we,
	input  tag_entry_t             tag_wr
);

	tag_entry_t entries [num_lines];

	// Reset invalidates every line and clears its dirty bit.
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			for (int i = 0; i < num_lines; i++)
			begin
				entries[i].valid <= 1'b0;
				entries[i].dirty <= 1'b0;
			end
		end
		else if (tag_we)
		begin
			entries[index] <= tag_wr;	// Whole entry replaced.
		end
	end

	// Combinational lookup of the indexed line.
	assign lookup = entries[index];

	// Hit needs a valid line with a matching tag.
	assign hit = lookup.valid && (lookup.tag == tag);

endmodule

//--- hdl/l1_data_store.sv
`timescale 1ns/1ps

module l1_data_store
	import l1_cache_pkg::*;
(
	input  logic                   clk,

	// Line select, shared by read and write.
	input  logic [index_width-1:0] index,

	// Write port.
	input  logic                   data_we,
	input  logic [data_width-1:0]  wr_word,

	// Read port.
	output logic [data_width-1:0]  rd_word
);

	logic [data_width-1:0] words [num_lines];

	// One word per line, written at the clock edge.
	always_ff @(posedge clk)
	begin
		if (data_we)
		begin
			words[index] <= wr_word;
		end
	end

	// Asynchronous read. The new word shows up after the write edge.
	assign rd_word = words[index];

endmodule

//--- hdl/l1_cache_ctrl.sv
`timescale 1ns/1ps

module l1_cache_ctrl
	import l1_cache_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,

	// CPU side.
	input  logic                   cache_cs,
	input  cpu_req_t               cache_req,
	output logic                   cache_ack,
	output logic [data_width-1:0]  cache_rdata,

	// Tag store.
	output logic [index_width-1:0] index,
	output logic [tag_width-1:0]   tag,
	input  tag_entry_t             lookup,
	input  logic                   hit,
	output logic                   tag_we,
	output tag_entry_t             tag_wr,

	// Data store.
	input  logic [data_width-1:0]  rd_word,
	output logic                   data_we,
	output logic [data_width-1:0]  wr_word,

	// DRAM side.
	output logic                   dram_cs,
	output dram_req_t              dram_req,
	input  logic [data_width-1:0]  dram_rdata,
	input  logic                   dram_ack
);

	cache_state_e          state;
	cache_state_e          next_state;
	cpu_req_t              req_q;		// Request held for the whole transaction.
	logic [data_width-1:0] dram_word;	// Fill word from DRAM.
	logic                  data_sel;	// 1 selects the DRAM word for the store.

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= st_idle;
		else
			state <= next_state;
	end

	// Request is sampled only when leaving idle.
	always_ff @(posedge clk)
	begin
		if (state == st_idle && cache_cs)
			req_q <= cache_req;
	end

	// DRAM data is only valid with the ack pulse, so keep it for the fill.
	always_ff @(posedge clk)
	begin
		if (dram_ack && !dram_req.we)
			dram_word <= dram_rdata;
	end

	assign index = addr_index(req_q.addr);
	assign tag   = addr_tag(req_q.addr);

	// Next state.
	always_comb
	begin
		next_state = state;
		case (state)
			st_idle:           if (cache_cs) next_state = st_compare;
			st_compare:
			begin
				if (hit)
					next_state = req_q.we ? st_write_hit : st_idle;
				else if (lookup.valid && lookup.dirty)
					next_state = st_write_back;	// Victim must go out first.
				else
					next_state = req_q.we ? st_write_miss : st_read_miss;
			end
			st_read_miss:      next_state = st_read_mem;
			st_read_mem:       if (dram_ack) next_state = st_read_data;
			st_read_data:      next_state = st_idle;
			st_write_hit:      next_state = st_idle;
			st_write_miss:     next_state = st_write_mem;
			st_write_mem:      if (dram_ack) next_state = st_write_data;
			st_write_data:     next_state = st_write_hit;
			st_write_back:     next_state = st_write_back_mem;
			st_write_back_mem: if (dram_ack) next_state = st_compare;
			default:           next_state = st_idle;
		endcase
	end

	// Output decode.
	always_comb
	begin
		cache_ack      = 1'b0;
		tag_we         = 1'b0;
		tag_wr.valid   = 1'b1;
		tag_wr.dirty   = 1'b0;
		tag_wr.tag     = tag;
		data_we        = 1'b0;
		data_sel       = 1'b0;
		dram_cs        = 1'b0;
		dram_req.we    = 1'b0;
		dram_req.addr  = req_q.addr;
		dram_req.wdata = '0;
		case (state)
			st_compare:    cache_ack = hit && !req_q.we;	// Read hit.
			st_read_mem,
			st_write_mem:  dram_cs = 1'b1;	// Line fetch.
			st_read_data:
			begin
				// Fill clean and hand the DRAM word straight to the CPU.
				cache_ack = 1'b1;
				tag_we    = 1'b1;
				data_we   = 1'b1;
				data_sel  = 1'b1;
			end
			st_write_data:
			begin
				tag_we   = 1'b1;
				data_we  = 1'b1;
				data_sel = 1'b1;
			end
			st_write_hit:
			begin
				cache_ack    = 1'b1;
				tag_we       = 1'b1;
				tag_wr.dirty = 1'b1;
				data_we      = 1'b1;
			end
			st_write_back_mem:
			begin
				dram_cs        = 1'b1;
				dram_req.we    = 1'b1;
				dram_req.addr  = make_addr(lookup.tag, index);	// Victim address.
				dram_req.wdata = rd_word;
				tag_we         = dram_ack;	// Line is clean once DRAM takes it.
				tag_wr.tag     = lookup.tag;
			end
			default: ;
		endcase
	end

	assign wr_word     = data_sel ? dram_word : req_q.wdata;
	assign cache_rdata = (state == st_read_data) ? dram_word : rd_word;

endmodule

//--- hdl/l1_cache_top.sv
`timescale 1ns/1ps

module l1_cache_top
	import l1_cache_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,

	// CPU port.
	input  logic                  cache_cs,
	input  cpu_req_t              cache_req,
	output logic [data_width-1:0] cache_rdata,
	output logic                  cache_ack,

	// DRAM port.
	output logic                  dram_cs,
	output dram_req_t             dram_req,
	input  logic [data_width-1:0] dram_rdata,
	input  logic                  dram_ack
);

	// Shared line select and tag from the registered request.
	logic [index_width-1:0] index;
	logic [tag_width-1:0]   tag;

	// Tag store.
	tag_entry_t             lookup;
	logic                   hit;
	logic                   tag_we;
	tag_entry_t             tag_wr;

	// Data store.
	logic [data_width-1:0]  rd_word;
	logic                   data_we;
	logic [data_width-1:0]  wr_word;

	l1_tag_store u_l1_tag_store (
		.clk    (clk),
		.rst    (rst),
		.index  (index),
		.tag    (tag),
		.tag_we (tag_we),
		.tag_wr (tag_wr),
		.lookup (lookup),
		.hit    (hit)
	);

	l1_data_store u_l1_data_store (
		.clk     (clk),
		.index   (index),
		.data_we (data_we),
		.wr_word (wr_word),
		.rd_word (rd_word)
	);

	l1_cache_ctrl u_l1_cache_ctrl (
		.clk         (clk),
		.rst         (rst),
		.cache_cs    (cache_cs),
		.cache_req   (cache_req),
		.cache_ack   (cache_ack),
		.cache_rdata (cache_rdata),
		.index       (index),
		.tag         (tag),
		.lookup      (lookup),
		.hit         (hit),
		.tag_we      (tag_we),
		.tag_wr      (tag_wr),
		.rd_word     (rd_word),
		.data_we     (data_we),
		.wr_word     (wr_word),
		.dram_cs     (dram_cs),
		.dram_req    (dram_req),
		.dram_rdata  (dram_rdata),
		.dram_ack    (dram_ack)
	);

endmodule

//--- dv/l1_cache_assertions.sv
`timescale 1ns/1ps

module l1_cache_assertions
	import l1_cache_pkg::*;
(
	input logic      clk,
	input logic      rst,
	input logic      cache_ack,
	input logic      dram_cs,
	input dram_req_t dram_req,
	input logic      dram_ack
);

	// CPU acknowledge is a single-cycle pulse.
	ack_single_pulse: assert property (
		@(posedge clk) disable iff (!rst) cache_ack |=> !cache_ack
	) else $error("cache_ack stayed high for more than one cycle");

	// A pending DRAM request keeps its command until DRAM takes it.
	dram_req_held: assert property (
		@(posedge clk) disable iff (!rst)
		dram_cs && !dram_ack |=> dram_cs && $stable(dram_req)
	) else $error("dram_req changed or dram_cs dropped before dram_ack");

	// Both request outputs are quiet right after reset.
	quiet_after_reset: assert property (
		@(posedge clk) !rst |=> !cache_ack && !dram_cs
	) else $error("cache_ack or dram_cs high in the cycle after reset");

endmodule

bind l1_cache_ctrl l1_cache_assertions u_l1_cache_assertions (
	.clk       (clk),
	.rst       (rst),
	.cache_ack (cache_ack),
	.dram_cs   (dram_cs),
	.dram_req  (dram_req),
	.dram_ack  (dram_ack)
);

//--- dv/l1_cache_tb.sv
`timescale 1ns/1ps

module l1_cache_tb
	import l1_cache_pkg::*;
();

	logic                  clk;
	logic                  rst;
	logic                  cache_cs;
	cpu_req_t              cache_req;
	logic [data_width-1:0] cache_rdata;
	logic                  cache_ack;
	logic                  dram_cs;
	dram_req_t             dram_req;
	logic [data_width-1:0] dram_rdata;
	logic                  dram_ack;

	logic [data_width-1:0] dram_mem [1 << addr_width];	// DRAM model contents.
	logic [data_width-1:0] shadow   [1 << addr_width];	// Current word of each address.
	bit                    written  [1 << addr_width];
	dram_req_t             dram_log [$];	// Every DRAM transfer, in order.
	int                    dram_writes;
	bit                    dram_busy;
	int                    dram_delay;
	integer                seed;
	int                    check_count;
	int                    error_count;
	int                    test_base;

	l1_cache_top u_l1_cache_top (
		.clk         (clk),
		.rst         (rst),
		.cache_cs    (cache_cs),
		.cache_req   (cache_req),
		.cache_rdata (cache_rdata),
		.cache_ack   (cache_ack),
		.dram_cs     (dram_cs),
		.dram_req    (dram_req),
		.dram_rdata  (dram_rdata),
		.dram_ack    (dram_ack)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Expected read data from the shadow memory.
	function automatic logic [data_width-1:0] ref_read(input logic [addr_width-1:0] addr);
		return shadow[addr];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input string name);
		$display("%-26s %s (%0d errors)", name,
			(error_count == test_base) ? "ok" : "FAILED", error_count - test_base);
		test_base = error_count;
	endtask

	// One CPU transfer. Holds the request until the ack edge, then idles a cycle.
	task automatic cpu_access(input logic we, input logic [addr_width-1:0] addr,
		input logic [data_width-1:0] wdata);
		int wait_cycles;
		wait_cycles = 0;
		@(negedge clk);
		cache_cs  = 1'b1;
		cache_req = '{we: we, addr: addr, wdata: wdata};
		@(negedge clk);
		while (!cache_ack && wait_cycles < 100)	// Covers a write-back plus a fill.
		begin
			@(negedge clk);
			wait_cycles++;
		end
		if (!cache_ack)
		begin
			error_count++;
			$display("%0t ns: no acknowledge within timeout for address %h", $time, addr);
		end
		else if (we)
		begin
			shadow[addr]  = wdata;
			written[addr] = 1'b1;
		end
		@(negedge clk);
		cache_cs = 1'b0;
	endtask

	// DRAM model. Answers each request after 1 to 4 cycles.
	always @(negedge clk)
	begin
		dram_ack = 1'b0;
		if (!rst)
			dram_busy = 1'b0;
		else if (dram_cs && !dram_busy)
		begin
			dram_busy  = 1'b1;
			dram_delay = 1 + ({$random(seed)} % 4);
		end
		else if (dram_busy)
		begin
			dram_delay = dram_delay - 1;
			if (dram_delay == 0)
			begin
				dram_busy = 1'b0;
				dram_ack  = 1'b1;
				dram_log.push_back(dram_req);
				if (dram_req.we)
				begin
					dram_mem[dram_req.addr] = dram_req.wdata;
					dram_writes++;
				end
				else
					dram_rdata = dram_mem[dram_req.addr];	// Valid with the ack.
			end
		end
	end

	// Every read acknowledge is checked against the shadow memory.
	always @(negedge clk)
	begin
		if (rst && cache_cs && cache_ack && !cache_req.we)
			check_value("cache_rdata", cache_rdata, ref_read(cache_req.addr));
	end

	initial
	begin
		logic [addr_width-1:0] addr;
		logic [addr_width-1:0] addr_b;
		seed        = 32'h157f_c918;
		rst         = 1'b0;
		cache_cs    = 1'b0;
		cache_req   = '0;
		dram_ack    = 1'b0;
		dram_rdata  = '0;
		dram_busy   = 1'b0;
		dram_delay  = 0;
		dram_writes = 0;
		check_count = 0;
		error_count = 0;
		test_base   = 0;
		for (int i = 0; i < (1 << addr_width); i++)
		begin
			dram_mem[i] = $random(seed);
			shadow[i]   = dram_mem[i];
			written[i]  = 1'b0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;

		repeat (5)
		begin
			@(negedge clk);
			check_value("cache_ack", cache_ack, 1'b0);
			check_value("dram_cs", dram_cs, 1'b0);
		end
		report_test("idle after reset");

		// Cold read fills from DRAM, the repeat read hits.
		addr = 10'h035;
		dram_log.delete();
		cpu_access(1'b0, addr, '0);
		check_value("dram transfers", dram_log.size(), 1);
		if (dram_log.size() == 1)
		begin
			check_value("dram_req.we", dram_log[0].we, 1'b0);
			check_value("dram_req.addr", dram_log[0].addr, addr);
		end
		dram_log.delete();
		cpu_access(1'b0, addr, '0);
		check_value("dram transfers", dram_log.size(), 0);
		report_test("cold read and read hit");

		dram_log.delete();
		cpu_access(1'b1, addr, 32'hcafe_0035);
		cpu_access(1'b0, addr, '0);
		check_value("dram transfers", dram_log.size(), 0);
		report_test("write hit");

		// Same index 7, tags 0x04 and 0x0c.
		addr   = 10'h047;
		addr_b = 10'h0c7;
		cpu_access(1'b1, addr, 32'h5a5a_0047);
		dram_log.delete();
		cpu_access(1'b0, addr_b, '0);
		check_value("dram transfers", dram_log.size(), 2);
		if (dram_log.size() == 2)
		begin
			check_value("dram_req.we", dram_log[0].we, 1'b1);
			check_value("dram_req.addr", dram_log[0].addr, addr);
			check_value("dram_req.wdata", dram_log[0].wdata, 32'h5a5a_0047);
			check_value("dram_req.we", dram_log[1].we, 1'b0);
			check_value("dram_req.addr", dram_log[1].addr, addr_b);
		end
		check_value("dram_mem", dram_mem[addr], 32'h5a5a_0047);
		report_test("dirty victim write-back");

		addr   = 10'h019;
		addr_b = 10'h159;
		cpu_access(1'b0, addr, '0);	// Leaves line 9 clean.
		dram_log.delete();
		cpu_access(1'b1, addr_b, 32'h0bad_f00d);
		check_value("dram transfers", dram_log.size(), 1);
		if (dram_log.size() == 1)
		begin
			check_value("dram_req.we", dram_log[0].we, 1'b0);
			check_value("dram_req.addr", dram_log[0].addr, addr_b);
		end
		cpu_access(1'b0, addr_b, '0);
		check_value("dram transfers", dram_log.size(), 1);
		report_test("write miss to clean line");

		for (int n = 0; n < 300; n++)
		begin
			addr = 10'h200 + ({$random(seed)} % 64);
			if ({$random(seed)} % 2)
				cpu_access(1'b1, addr, $random(seed));
			else
				cpu_access(1'b0, addr, '0);
		end
		// Conflicting reads push every dirty line out to DRAM.
		for (int i = 0; i < num_lines; i++)
			cpu_access(1'b0, {6'h3f, i[index_width-1:0]}, '0);
		for (int i = 0; i < (1 << addr_width); i++)
		begin
			if (written[i])
				check_value($sformatf("dram_mem[%0h]", i), dram_mem[i], shadow[i]);
		end
		report_test("random traffic and flush");

		$display("checks: %0d, errors: %0d, dram write-backs: %0d",
			check_count, error_count, dram_writes);
		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- src.f
hdl/l1_cache_pkg.sv
hdl/l1_tag_store.sv
hdl/l1_data_store.sv
hdl/l1_cache_ctrl.sv
hdl/l1_cache_top.sv
dv/l1_cache_assertions.sv
dv/l1_cache_tb.sv

//--- Bender.yml
package:
  name: l1_cache

sources:
  - hdl/l1_cache_pkg.sv
  - hdl/l1_tag_store.sv
  - hdl/l1_data_store.sv
  - hdl/l1_cache_ctrl.sv
  - hdl/l1_cache_top.sv
  - target: simulation
    files:
      - dv/l1_cache_assertions.sv
      - dv/l1_cache_tb.sv
